// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := klClkDiag_tb
FILELIST  := klClkDiag.f
BUILD_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== clkDiagCtl.sv ====
`include "klClkDiag_params.svh"

module clkDiagCtl
  import ebusPkg::*;
  import clkPkg::*;
(
  input  logic       masterClk,
  input  logic       arstN,
  input  diagReq_t   popData,
  input  logic       empty,
  output logic       pop,
  output logic       eboxClkEn,
  output clkStatus_t status,
  output logic       idle
);

  clkRunState_t runState;
  clkRunState_t nextState;
  clkStatus_t   statusQ;
  clkRate_t     divCnt;
  logic         accepting;
  logic         clkFunc;
  logic         tick;

  // New functions only while stopped or free running
  assign accepting = (runState == clkStopped) || (runState == clkRunning);
  assign pop       = accepting && !empty;
  assign idle      = accepting && empty;
  assign clkFunc   = isClkFunc(popData.func);
  assign status    = statusQ;

  // Compare with >= so a smaller rate loaded mid-count takes effect at once
  assign tick = (divCnt >= statusQ.rate);

  // Processor reset holds the clock enable off
  always_comb begin
    case (runState)
      clkRunning:  eboxClkEn = tick && !statusQ.eboxReset;
      clkStepping: eboxClkEn = !statusQ.eboxReset;
      clkBursting: eboxClkEn = tick && (statusQ.burstCount != '0) && !statusQ.eboxReset;
      default:     eboxClkEn = 1'b0;
    endcase
  end

  always_comb begin
    nextState = runState;
    case (runState)
      clkStopped, clkRunning: begin
        if (pop && clkFunc) begin
          case (popData.func)
            `FN_STOP:  nextState = clkStopped;
            `FN_START: nextState = clkRunning;
            `FN_STEP:  nextState = clkStepping;
            `FN_BURST: nextState = clkBursting;
            default:   nextState = runState;
          endcase
        end
      end
      // Single step lasts one cycle
      clkStepping: nextState = clkStopped;
      // Burst ends once the counter has run down
      clkBursting: begin
        if (statusQ.burstCount == '0) begin
          nextState = clkStopped;
        end
      end
      default: nextState = clkStopped;
    endcase
  end

  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      runState <= clkStopped;
      divCnt   <= '0;
    end else begin
      runState <= nextState;
      // Divider restarts on every mode change
      if (nextState != runState || nextState == clkStopped || nextState == clkStepping) begin
        divCnt <= '0;
      end else begin
        divCnt <= tick ? '0 : clkRate_t'(divCnt + 1'b1);
      end
    end
  end

  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      statusQ <= clkStatusReset;
    end else if (pop && clkFunc) begin
      case (popData.func)
        `FN_STOP:                statusQ.running <= 1'b0;
        `FN_START:               statusQ.running <= 1'b1;
        `FN_STEP, `FN_BURST:     statusQ.running <= 1'b0;
        `FN_CLR_RESET:           statusQ.eboxReset <= 1'b0;
        `FN_SET_RESET:           statusQ.eboxReset <= 1'b1;
        `FN_LD_BURST_R:          statusQ.burstCount[3:0] <= popData.data[3:0];
        `FN_LD_BURST_L:          statusQ.burstCount[7:4] <= popData.data[3:0];
        `FN_LD_SRC_RATE: begin
          statusQ.source <= popData.data[4:3];
          statusQ.rate   <= popData.data[2:0];
        end
        `FN_LD_PARITY:           statusQ.parityEn <= popData.data[2:0];
        `FN_KL_OPCODES:          statusQ.klOpcodes <= popData.data[0];
        // Sticky until master reset
        default:                 statusQ.funcError <= 1'b1;
      endcase
    end else if (runState == clkBursting && tick && statusQ.burstCount != '0) begin
      // Count down even under processor reset
      statusQ.burstCount <= statusQ.burstCount - 1'b1;
    end
  end

  // No clock while the reported status has the processor stopped
  stoppedNoClock: assert property (@(posedge masterClk) disable iff (!arstN)
    (!statusQ.running && runState != clkStepping && runState != clkBursting)
      |-> !eboxClkEn);

endmodule

// ==== clkPkg.sv ====
`include "klClkDiag_params.svh"

package clkPkg;

  // Divider setting
  // Processor clock enable every rate+1 master clocks
  typedef logic [`RATE_W-1:0] clkRate_t;

  // Clock source select, stored only
  typedef logic [1:0] clkSource_t;

  // Burst length in processor clocks
  typedef logic [`BURST_W-1:0] burstCnt_t;

  // Bit 2 FM, bit 1 CRAM, bit 0 DRAM
  typedef logic [2:0] parityEn_t;

  // How the processor clock enable is being generated
  typedef enum logic [1:0] {
    clkStopped,
    clkRunning,
    clkStepping,
    clkBursting
  } clkRunState_t;

  // Controller state as seen by the front end
  typedef struct packed {
    clkSource_t source;
    clkRate_t   rate;
    burstCnt_t  burstCount;
    parityEn_t  parityEn;
    logic       klOpcodes;
    logic       eboxReset;
    logic       running;
    logic       funcError;
  } clkStatus_t;

  // Power-up value with the processor held in reset
  localparam clkStatus_t clkStatusReset = '{
    source:     '0,
    rate:       '0,
    burstCount: '0,
    parityEn:   '0,
    klOpcodes:  1'b0,
    eboxReset:  1'b1,
    running:    1'b0,
    funcError:  1'b0
  };

endpackage

// ==== diagCmdFifo.sv ====
`include "klClkDiag_params.svh"

module diagCmdFifo
  import ebusPkg::*;
#(
  parameter int depth = `DIAG_FIFO_DEPTH
) (
  input  logic     masterClk,
  input  logic     arstN,
  input  logic     push,
  input  diagReq_t pushData,
  input  logic     pop,
  output diagReq_t popData,
  output logic     empty,
  output logic     full
);

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int lastIdx = depth - 1;

  // Storage holds payload only
  diagReq_t        mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   count;

  assign empty   = (count == '0);
  assign full    = (count == (ptrW + 1)'(depth));
  assign popData = mem[rdPtr];

  always_ff @(posedge masterClk) begin
    if (push) begin
      mem[wrPtr] <= pushData;
    end
  end

  // Pointers wrap at depth so any depth works
  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == ptrW'(lastIdx)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == ptrW'(lastIdx)) ? '0 : rdPtr + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  noPushWhenFull: assert property (@(posedge masterClk) disable iff (!arstN)
    push |-> !full);
  noPopWhenEmpty: assert property (@(posedge masterClk) disable iff (!arstN)
    pop |-> !empty);

endmodule

// ==== diagCmdIssuer.sv ====
module diagCmdIssuer
  import ebusPkg::*;
(
  input  logic     masterClk,
  input  logic     arstN,
  input  logic     cmdReq,
  input  diagReq_t cmd,
  input  logic     full,
  output logic     cmdAck,
  output logic     push,
  output diagReq_t pushData
);

  // Handshake phase
  typedef enum logic {
    waitReq,
    waitRelease
  } issuerState_t;

  issuerState_t state;
  issuerState_t nextState;

  // Take the command only when there is room
  // The front end keeps cmd stable until it sees the ack
  assign push     = (state == waitReq) && cmdReq && !full;
  assign pushData = cmd;

  // Ack follows the state so it rises the edge after the push
  assign cmdAck = (state == waitRelease);

  always_comb begin
    nextState = state;
    case (state)
      waitReq: begin
        if (push) begin
          nextState = waitRelease;
        end
      end
      waitRelease: begin
        // Drop ack once the front end lets go of req
        if (!cmdReq) begin
          nextState = waitReq;
        end
      end
      default: nextState = waitReq;
    endcase
  end

  always_ff @(posedge masterClk or negedge arstN) begin
    if (!arstN) begin
      state <= waitReq;
    end else begin
      state <= nextState;
    end
  end

  // Front end may let go of req only once the ack is up
  reqHeldUntilAck: assert property (@(posedge masterClk) disable iff (!arstN)
    $fell(cmdReq) |-> cmdAck);

endmodule

// ==== ebusPkg.sv ====
`include "klClkDiag_params.svh"

package ebusPkg;

  // Diagnostic function code
  // Top bits pick the controller, low bits pick the function
  typedef logic [`DIAG_FUNC_W-1:0] diagFunc_t;

  // One EBUS data word
  typedef logic [`EBUS_DATA_W-1:0] ebusData_t;

  // Request as it moves from the front end through the FIFO
  typedef struct packed {
    diagFunc_t func;
    ebusData_t data;
  } diagReq_t;

  // Clock controller owns codes 000 to 077
  // Anything with a nonzero top octal digit is for another controller
  function automatic logic isClkFunc(diagFunc_t func);
    return func[`DIAG_FUNC_W-1 -: 3] == 3'b000;
  endfunction

endpackage

// ==== klClkDiag.f ====
+incdir+.
ebusPkg.sv
clkPkg.sv
diagCmdIssuer.sv
diagCmdFifo.sv
clkDiagCtl.sv
klClkDiag.sv
klClkDiag_tb.sv

// ==== klClkDiag.sv ====
module klClkDiag
  import ebusPkg::*;
  import clkPkg::*;
(
  input  logic       masterClk,
  input  logic       arstN,
  input  logic       cmdReq,
  input  diagReq_t   cmd,
  output logic       cmdAck,
  output logic       eboxClkEn,
  output clkStatus_t status,
  output logic       idle
);

  // Issuer to FIFO
  logic     push;
  diagReq_t pushData;
  logic     full;

  // FIFO to clock controller
  diagReq_t popData;
  logic     empty;
  logic     pop;

  // Front-end handshake side
  diagCmdIssuer issuer (
    .masterClk (masterClk),
    .arstN     (arstN),
    .cmdReq    (cmdReq),
    .cmd       (cmd),
    .full      (full),
    .cmdAck    (cmdAck),
    .push      (push),
    .pushData  (pushData)
  );

  diagCmdFifo cmdFifo (
    .masterClk (masterClk),
    .arstN     (arstN),
    .push      (push),
    .pushData  (pushData),
    .pop       (pop),
    .popData   (popData),
    .empty     (empty),
    .full      (full)
  );

  // Executes clock functions and drives the processor clock enable
  clkDiagCtl clkCtl (
    .masterClk (masterClk),
    .arstN     (arstN),
    .popData   (popData),
    .empty     (empty),
    .pop       (pop),
    .eboxClkEn (eboxClkEn),
    .status    (status),
    .idle      (idle)
  );

endmodule

// ==== klClkDiag_params.svh ====
`ifndef KLCLKDIAG_PARAMS_SVH
`define KLCLKDIAG_PARAMS_SVH

// Widths of the EBUS diagnostic command
`define DIAG_FUNC_W      9
`define EBUS_DATA_W      36

// Requests held between the front end and the clock controller
`define DIAG_FIFO_DEPTH  4

// Clock controller field widths
`define RATE_W           3
`define BURST_W          8

// Clock controller diagnostic functions
`define FN_STOP          9'o000
`define FN_START         9'o001
`define FN_STEP          9'o002
`define FN_BURST         9'o003
`define FN_CLR_RESET     9'o006
`define FN_SET_RESET     9'o007
`define FN_LD_BURST_R    9'o042
`define FN_LD_BURST_L    9'o043
`define FN_LD_SRC_RATE   9'o044
`define FN_LD_PARITY     9'o046
`define FN_KL_OPCODES    9'o067

`endif

// ==== klClkDiag_tb.sv ====
`include "klClkDiag_params.svh"

module klClkDiag_tb
  import ebusPkg::*;
  import clkPkg::*;
();

  // Commands in the whole run, rounded up
  localparam int numCmds = 64;
  // Worst case per command is a 256 long burst at rate 7
  localparam int watchdogCycles = numCmds * 256 * 8 + 2000;

  logic       masterClk;
  logic       arstN;
  logic       cmdReq;
  diagReq_t   cmd;
  logic       cmdAck;
  logic       eboxClkEn;
  clkStatus_t status;
  logic       idle;

  integer     seed;
  int         pulseCnt;
  clkStatus_t model;
  event       checkStart;
  event       checkDone;

  klClkDiag dut_i (
    .masterClk (masterClk),
    .arstN     (arstN),
    .cmdReq    (cmdReq),
    .cmd       (cmd),
    .cmdAck    (cmdAck),
    .eboxClkEn (eboxClkEn),
    .status    (status),
    .idle      (idle)
  );

  always #4 masterClk = ~masterClk;

  // Processor clock enable pulses, sampled mid-cycle
  always @(negedge masterClk) begin
    if (eboxClkEn) begin
      pulseCnt = pulseCnt + 1;
    end
  end

  task automatic checkEq(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Expected controller status after one command
  function automatic clkStatus_t refApply(clkStatus_t s, diagReq_t r);
    clkStatus_t n;
    n = s;
    // Nonzero top octal digit means another controller
    if (r.func[8:6] == 3'b000) begin
      case (r.func)
        `FN_STOP:        n.running = 1'b0;
        `FN_START:       n.running = 1'b1;
        `FN_STEP:        n.running = 1'b0;
        `FN_BURST: begin
          // Burst always runs down to zero
          n.running    = 1'b0;
          n.burstCount = '0;
        end
        `FN_CLR_RESET:   n.eboxReset = 1'b0;
        `FN_SET_RESET:   n.eboxReset = 1'b1;
        `FN_LD_BURST_R:  n.burstCount[3:0] = r.data[3:0];
        `FN_LD_BURST_L:  n.burstCount[7:4] = r.data[3:0];
        `FN_LD_SRC_RATE: begin
          n.source = r.data[4:3];
          n.rate   = r.data[2:0];
        end
        `FN_LD_PARITY:   n.parityEn = r.data[2:0];
        `FN_KL_OPCODES:  n.klOpcodes = r.data[0];
        default:         n.funcError = 1'b1;
      endcase
    end
    return n;
  endfunction

  function automatic diagReq_t mkReq(diagFunc_t f, logic [3:0] low);
    diagReq_t r;
    r.func = f;
    r.data = {32'b0, low};
    return r;
  endfunction

  // Compare process, runs once per request from the main sequence
  initial begin
    forever begin
      @(checkStart);
      @(negedge masterClk);
      while (!idle) begin
        @(negedge masterClk);
      end
      checkEq("status.source", 64'(status.source), 64'(model.source));
      checkEq("status.rate", 64'(status.rate), 64'(model.rate));
      checkEq("status.burstCount", 64'(status.burstCount), 64'(model.burstCount));
      checkEq("status.parityEn", 64'(status.parityEn), 64'(model.parityEn));
      checkEq("status.klOpcodes", 64'(status.klOpcodes), 64'(model.klOpcodes));
      checkEq("status.eboxReset", 64'(status.eboxReset), 64'(model.eboxReset));
      checkEq("status.running", 64'(status.running), 64'(model.running));
      checkEq("status.funcError", 64'(status.funcError), 64'(model.funcError));
      -> checkDone;
    end
  end

  task automatic verifyStatus();
    -> checkStart;
    @(checkDone);
  endtask

  // Four-phase handshake, optionally checking that ack is held off
  task automatic sendCmd(input diagReq_t r, input int holdLow);
    @(negedge masterClk);
    cmd    = r;
    cmdReq = 1'b1;
    for (int i = 0; i < holdLow; i++) begin
      @(negedge masterClk);
      checkEq("cmdAck", 64'(cmdAck), 64'd0);
    end
    while (!cmdAck) begin
      @(negedge masterClk);
    end
    cmdReq = 1'b0;
    while (cmdAck) begin
      @(negedge masterClk);
    end
  endtask

  task automatic issue(input diagReq_t r, input int holdLow);
    sendCmd(r, holdLow);
    model = refApply(model, r);
  endtask

  task automatic randomLoad(output diagReq_t r);
    logic [31:0] pick;
    logic [31:0] hi;
    logic [31:0] lo;
    pick   = $random(seed);
    hi     = $random(seed);
    lo     = $random(seed);
    r.data = {hi[3:0], lo};
    case (pick % 32'd6)
      32'd0:   r.func = `FN_LD_BURST_R;
      32'd1:   r.func = `FN_LD_BURST_L;
      32'd2:   r.func = `FN_LD_SRC_RATE;
      32'd3:   r.func = `FN_LD_PARITY;
      32'd4:   r.func = `FN_KL_OPCODES;
      // Some other controller
      default: r.func = 9'o100 | pick[16:8];
    endcase
  endtask

  initial begin
    repeat (watchdogCycles) @(posedge masterClk);
    $display("Simulation FAILED");
    $fatal(1, "Watchdog expired before all tests finished");
  end

  initial begin
    diagReq_t    r;
    logic [31:0] rnd;
    logic [7:0]  burstN;
    int          startCnt;
    int          freeCnt;
    masterClk = 1'b0;
    arstN     = 1'b0;
    cmdReq    = 1'b0;
    cmd       = '0;
    seed      = 32'h70b4;
    pulseCnt  = 0;
    model     = '{source: '0, rate: '0, burstCount: '0, parityEn: '0, klOpcodes: 1'b0,
                  eboxReset: 1'b1, running: 1'b0, funcError: 1'b0};
    repeat (2) @(negedge masterClk);
    arstN = 1'b1;
    checkEq("cmdAck", 64'(cmdAck), 64'd0);
    checkEq("eboxClkEn", 64'(eboxClkEn), 64'd0);
    verifyStatus();

    // Master reset sequence as the console runs it
    issue(mkReq(`FN_SET_RESET, 4'h0), 0);
    issue(mkReq(`FN_CLR_RESET, 4'h0), 0);
    issue(mkReq(`FN_STOP, 4'h0), 0);
    issue(mkReq(`FN_LD_SRC_RATE, 4'h0), 0);
    issue(mkReq(`FN_LD_PARITY, 4'h0), 0);
    issue(mkReq(`FN_LD_BURST_R, 4'h0), 0);
    issue(mkReq(`FN_LD_BURST_L, 4'h0), 0);
    issue(mkReq(`FN_KL_OPCODES, 4'h1), 0);
    verifyStatus();
    checkEq("status.eboxReset", 64'(status.eboxReset), 64'd0);
    checkEq("status.klOpcodes", 64'(status.klOpcodes), 64'd1);

    // Random loads, foreign codes included
    for (int i = 0; i < 20; i++) begin
      randomLoad(r);
      issue(r, 0);
      verifyStatus();
    end

    // Single step
    startCnt = pulseCnt;
    issue(mkReq(`FN_STEP, 4'h0), 0);
    verifyStatus();
    checkEq("stepPulses", 64'(pulseCnt - startCnt), 64'd1);

    // Burst of random length at a random rate
    rnd    = $random(seed);
    burstN = (rnd[7:0] == 8'd0) ? 8'd1 : rnd[7:0];
    issue(mkReq(`FN_LD_SRC_RATE, rnd[11:8]), 0);
    issue(mkReq(`FN_LD_BURST_R, burstN[3:0]), 0);
    issue(mkReq(`FN_LD_BURST_L, burstN[7:4]), 0);
    startCnt = pulseCnt;
    issue(mkReq(`FN_BURST, 4'h0), 0);
    verifyStatus();
    checkEq("burstPulses", 64'(pulseCnt - startCnt), 64'(burstN));

    // Same burst with the processor held in reset
    issue(mkReq(`FN_SET_RESET, 4'h0), 0);
    issue(mkReq(`FN_LD_BURST_R, burstN[3:0]), 0);
    issue(mkReq(`FN_LD_BURST_L, burstN[7:4]), 0);
    startCnt = pulseCnt;
    issue(mkReq(`FN_BURST, 4'h0), 0);
    verifyStatus();
    checkEq("resetBurstPulses", 64'(pulseCnt - startCnt), 64'd0);
    issue(mkReq(`FN_CLR_RESET, 4'h0), 0);

    // Free run over 40 enable periods
    rnd = $random(seed);
    issue(mkReq(`FN_LD_SRC_RATE, rnd[3:0]), 0);
    issue(mkReq(`FN_START, 4'h0), 0);
    verifyStatus();
    startCnt = pulseCnt;
    repeat (40 * (int'(model.rate) + 1)) @(negedge masterClk);
    freeCnt = pulseCnt - startCnt;
    // One pulse either way depends on the window phase
    checkEq("freeRunPulsesWithinOneOf40", 64'(freeCnt >= 39 && freeCnt <= 41), 64'd1);
    issue(mkReq(`FN_STOP, 4'h0), 0);
    verifyStatus();
    startCnt = pulseCnt;
    repeat (50) @(negedge masterClk);
    checkEq("stoppedPulses", 64'(pulseCnt - startCnt), 64'd0);

    // Long burst keeps the FIFO from draining
    issue(mkReq(`FN_LD_BURST_R, 4'h8), 0);
    issue(mkReq(`FN_LD_BURST_L, 4'hc), 0);
    startCnt = pulseCnt;
    issue(mkReq(`FN_BURST, 4'h0), 0);
    // Burst still running, so not every command has taken effect
    checkEq("idle", 64'(idle), 64'd0);
    for (int i = 0; i < 6; i++) begin
      randomLoad(r);
      // Fifth load finds the FIFO full
      issue(r, (i == 4) ? 16 : 0);
    end
    verifyStatus();
    checkEq("backPressurePulses", 64'(pulseCnt - startCnt), 64'd200);

    // Unknown clock function
    issue(mkReq(9'o005, 4'h0), 0);
    verifyStatus();
    checkEq("status.funcError", 64'(status.funcError), 64'd1);

    $display("Simulation PASSED");
    $finish;
  end

endmodule
